// File: rs_defs.svh
/* scheduler sizing: queue count, queue depth, register file size and age rank width */
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// number of reservation-station issue queues
`define RS_NUM_QUEUES 4

// entries held by each queue
`define RS_NUM_ENTRIES 4

// architectural integer registers, r0 reads as always ready
`define RS_REG_NUM 32

// age rank per entry, 0 is the oldest in its queue
`define RS_AGE_WIDTH 2

`endif

// File: isa_pkg.sv
/* instruction-set package: alu opcodes and the two decode views of one
   32-bit instruction word (register-register and register-immediate) */
`default_nettype none

package isa_pkg;

    typedef logic [4:0]  reg_idx_t;  // architectural register index
    typedef logic [16:0] imm_t;      // i-form immediate field

    // bit 31 picks which view of the word applies
    typedef enum logic {
        FORM_R = 1'b0,
        FORM_I = 1'b1
    } insn_form_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,  // shift left
        ALU_SRL = 4'h6,  // logical shift right
        ALU_SLT = 4'h7   // set if less than, signed
    } alu_op_e;

    // r-form: dst = src1 op src2
    typedef struct packed {
        insn_form_e form;   // [31]
        alu_op_e    op;     // [30:27]
        reg_idx_t   dst;    // [26:22]
        reg_idx_t   src1;   // [21:17]
        reg_idx_t   src2;   // [16:12]
        logic [11:0] pad;   // unused, reads as don't care
    } insn_r_t;

    // i-form: dst = src1 op imm
    typedef struct packed {
        insn_form_e form;
        alu_op_e    op;
        reg_idx_t   dst;
        reg_idx_t   src1;
        imm_t       imm;    // [16:0]
    } insn_i_t;

    // form, op, dst and src1 sit at the same bits in both views
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_word_u;

endpackage

`default_nettype wire

// File: rs_pkg.sv
/* scheduler package: dispatch packet, issue packet and wakeup broadcast
   passed between dispatch, the issue queues and the arbiter */
`default_nettype none

package rs_pkg;

    // decoded instruction as written into a queue, with source readiness
    typedef struct packed {
        isa_pkg::alu_op_e  op;
        isa_pkg::reg_idx_t dst;
        isa_pkg::reg_idx_t src1;
        isa_pkg::reg_idx_t src2;  // r0 for i-form
        isa_pkg::imm_t     imm;   // zero for r-form
        logic              rdy1;  // src1 ready at dispatch
        logic              rdy2;  // src2 ready at dispatch
    } disp_pkt_t;

    // what leaves toward the execute port
    typedef struct packed {
        isa_pkg::alu_op_e  op;
        isa_pkg::reg_idx_t dst;
        isa_pkg::reg_idx_t src1;
        isa_pkg::reg_idx_t src2;
        isa_pkg::imm_t     imm;
    } issue_pkt_t;

    // dst of the instruction granted this cycle, never r0
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t dst;
    } wakeup_t;

    // drop the ready bits, queue tracks readiness on its own
    function automatic issue_pkt_t to_issue(input disp_pkt_t d);
        issue_pkt_t p;
        p.op   = d.op;
        p.dst  = d.dst;
        p.src1 = d.src1;
        p.src2 = d.src2;
        p.imm  = d.imm;
        return p;
    endfunction

endpackage

`default_nettype wire

// File: dispatch_unit.sv
/* dispatch: decodes the instruction word, keeps the register busy scoreboard
   and steers accepted instructions round-robin into non-full issue queues */
`default_nettype none
`include "rs_defs.svh"

module dispatch_unit (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      in_valid,
    input  wire isa_pkg::insn_word_u       in_word,
    input  wire logic [`RS_NUM_QUEUES-1:0] queue_full,
    input  wire rs_pkg::wakeup_t           wakeup,
    output logic                           in_ready,
    output logic [`RS_NUM_QUEUES-1:0]      disp_valid,
    output rs_pkg::disp_pkt_t              disp_pkt
);
    import isa_pkg::*;

    localparam int NQ = `RS_NUM_QUEUES;
    localparam int QW = (NQ > 1) ? $clog2(NQ) : 1;

    logic [`RS_REG_NUM-1:0] busy;  // 1 = a writer is still waiting to issue
    logic [QW-1:0] rr_ptr;          // next queue to try first
    logic [QW-1:0] sel_q;
    logic          form_i;
    reg_idx_t      src2_idx;
    logic          rdy1, rdy2;
    logic          dst_busy;
    logic          some_free;
    logic          fire;

    // decode, form/op/dst/src1 share bit positions so the r view serves both
    assign form_i   = (in_word.r.form == FORM_I);
    assign src2_idx = form_i ? '0 : in_word.r.src2;  // i-form reads r0, always ready

    // scoreboard read with same-cycle wakeup bypass
    assign rdy1 = !busy[in_word.r.src1] ||
                  (wakeup.valid && (wakeup.dst == in_word.r.src1));
    assign rdy2 = !busy[src2_idx] ||
                  (wakeup.valid && (wakeup.dst == src2_idx));

    // no renaming, so a second pending writer of dst has to wait
    assign dst_busy  = busy[in_word.r.dst];
    assign some_free = ~&queue_full;
    assign in_ready  = !reset && some_free && !dst_busy;
    assign fire      = in_valid && in_ready;

    always_comb begin
        disp_pkt.op   = in_word.r.op;
        disp_pkt.dst  = in_word.r.dst;
        disp_pkt.src1 = in_word.r.src1;
        disp_pkt.src2 = src2_idx;
        disp_pkt.imm  = form_i ? in_word.i.imm : '0;  // r-form carries no immediate
        disp_pkt.rdy1 = rdy1;
        disp_pkt.rdy2 = rdy2;
    end

    // first non-full queue at or after the pointer
    always_comb begin : pick_queue
        int unsigned q;
        logic        found;
        found = 1'b0;
        sel_q = rr_ptr;
        for (int k = 0; k < NQ; k++) begin
            q = (int'(rr_ptr) + k) % NQ;
            if (!found && !queue_full[q]) begin
                found = 1'b1;
                sel_q = QW'(q);
            end
        end
    end

    assign disp_valid = fire ? (NQ'(1) << sel_q) : '0;  // one-hot, only to a non-full queue

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= '0;  // all registers ready
            rr_ptr <= '0;
        end else begin
            if (wakeup.valid)
                busy[wakeup.dst] <= 1'b0;
            // set after clear so a new writer wins over a wakeup of the same reg
            if (fire && (in_word.r.dst != '0))
                busy[in_word.r.dst] <= 1'b1;
            if (fire)
                rr_ptr <= QW'((int'(sel_q) + 1) % NQ);  // move past the queue just used
        end
    end

endmodule

`default_nettype wire

// File: issue_queue.sv
/* reservation-station issue queue: holds entries with age rank and source
   ready bits, snoops wakeups and offers its oldest fully ready entry */
`default_nettype none
`include "rs_defs.svh"

module issue_queue (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              load,       // from dispatch, only while not full
    input  wire rs_pkg::disp_pkt_t entry_in,
    input  wire rs_pkg::wakeup_t   wakeup,
    input  wire logic              grant,      // from arbiter
    output logic                   full,
    output logic                   offer_valid,
    output rs_pkg::issue_pkt_t     offer_pkt
);
    import rs_pkg::*;

    localparam int NE = `RS_NUM_ENTRIES;
    localparam int AW = `RS_AGE_WIDTH;
    localparam int IW = (NE > 1) ? $clog2(NE) : 1;

    // per-entry control state
    logic [NE-1:0] valid;
    logic [NE-1:0] rdy1;
    logic [NE-1:0] rdy2;
    logic [AW-1:0] age [NE];  // 0 is oldest

    issue_pkt_t payload [NE];  // instruction fields, written on load

    logic [NE-1:0] ready;     // valid and both sources ready
    logic [AW:0]   count;     // 0..NE
    logic [IW-1:0] best_idx;  // oldest ready entry
    logic [AW-1:0] best_age;
    logic [IW-1:0] free_idx;  // slot for the next load
    logic [AW-1:0] new_age;
    logic          take;      // entry leaves this edge

    always_comb begin
        for (int i = 0; i < NE; i++)
            ready[i] = valid[i] && rdy1[i] && rdy2[i];
    end

    always_comb begin
        count = '0;
        for (int i = 0; i < NE; i++)
            count = count + (AW+1)'(valid[i]);
    end

    assign full = (count == (AW+1)'(NE));

    // lowest rank among ready entries, ranks are unique within the queue
    always_comb begin : pick_oldest
        logic found;
        found    = 1'b0;
        best_idx = '0;
        best_age = '0;
        for (int i = 0; i < NE; i++) begin
            if (ready[i] && (!found || (age[i] < best_age))) begin
                found    = 1'b1;
                best_idx = IW'(i);
                best_age = age[i];
            end
        end
        offer_valid = found;
    end

    assign offer_pkt = payload[best_idx];
    assign take      = offer_valid && grant;

    // first empty slot, only meaningful while not full
    always_comb begin : pick_free
        logic found;
        found    = 1'b0;
        free_idx = '0;
        for (int i = 0; i < NE; i++) begin
            if (!found && !valid[i]) begin
                found    = 1'b1;
                free_idx = IW'(i);
            end
        end
    end

    // newcomer is the youngest, one place earlier if an older entry leaves now
    assign new_age = AW'(count - (AW+1)'(take));

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            rdy1  <= '0;
            rdy2  <= '0;
            for (int i = 0; i < NE; i++)
                age[i] <= '0;
        end else begin
            // wakeup snoop, each source matched on its own
            for (int i = 0; i < NE; i++) begin
                if (valid[i] && wakeup.valid && (payload[i].src1 == wakeup.dst))
                    rdy1[i] <= 1'b1;
                if (valid[i] && wakeup.valid && (payload[i].src2 == wakeup.dst))
                    rdy2[i] <= 1'b1;
            end
            if (take) begin
                valid[best_idx] <= 1'b0;
                for (int i = 0; i < NE; i++) begin
                    if (valid[i] && (age[i] > best_age))
                        age[i] <= age[i] - 1'b1;  // younger ones move up
                end
            end
            // load last, free slot is never the granted one
            if (load) begin
                valid[free_idx] <= 1'b1;
                age[free_idx]   <= new_age;
                rdy1[free_idx]  <= entry_in.rdy1;  // dispatch already bypassed this wakeup
                rdy2[free_idx]  <= entry_in.rdy2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            payload[free_idx] <= to_issue(entry_in);
    end

endmodule

`default_nettype wire

// File: issue_arbiter.sv
/* issue arbiter: round-robin grant over queue offers into the execute output
   register, broadcasting the granted dst as a wakeup */
`default_nettype none
`include "rs_defs.svh"

module issue_arbiter (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic [`RS_NUM_QUEUES-1:0] offer_valid,
    input  wire rs_pkg::issue_pkt_t        offer_pkt [`RS_NUM_QUEUES],
    input  wire logic                      out_ready,
    output logic [`RS_NUM_QUEUES-1:0]      grant,
    output rs_pkg::wakeup_t                wakeup,
    output logic                           out_valid,
    output rs_pkg::issue_pkt_t             out_pkt
);
    import rs_pkg::*;

    localparam int NQ = `RS_NUM_QUEUES;
    localparam int QW = (NQ > 1) ? $clog2(NQ) : 1;

    logic [QW-1:0] rr_ptr;    // highest priority queue this cycle
    logic [QW-1:0] sel_q;
    logic          found;
    logic          can_load;  // output register empty or draining
    logic          take;
    issue_pkt_t    sel_pkt;

    assign can_load = !out_valid || out_ready;

    always_comb begin : pick_offer
        int unsigned q;
        found = 1'b0;
        sel_q = rr_ptr;
        for (int k = 0; k < NQ; k++) begin
            q = (int'(rr_ptr) + k) % NQ;
            if (!found && offer_valid[q]) begin
                found = 1'b1;
                sel_q = QW'(q);
            end
        end
    end

    assign take    = can_load && found;
    assign sel_pkt = offer_pkt[sel_q];
    assign grant   = take ? (NQ'(1) << sel_q) : '0;  // at most one per cycle

    // consumers see it this cycle, ready in their entries from the next
    always_comb begin
        wakeup.valid = take && (sel_pkt.dst != '0);  // r0 is never busy
        wakeup.dst   = sel_pkt.dst;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            rr_ptr    <= '0;
        end else if (can_load) begin
            out_valid <= found;
            if (found)
                rr_ptr <= QW'((int'(sel_q) + 1) % NQ);
        end
    end

    // holds while stalled, so out_pkt is steady under back-pressure
    always_ff @(posedge clk) begin
        if (take)
            out_pkt <= sel_pkt;
    end

endmodule

`default_nettype wire

// File: rs_top.sv
/* scheduling core top: dispatch, a bank of issue queues and the issue arbiter */
`default_nettype none
`include "rs_defs.svh"

module rs_top (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                in_valid,
    input  wire isa_pkg::insn_word_u in_word,
    input  wire logic                out_ready,
    output logic                     in_ready,
    output logic                     out_valid,
    output rs_pkg::issue_pkt_t       out_pkt
);
    import rs_pkg::*;

    logic [`RS_NUM_QUEUES-1:0] queue_full;
    logic [`RS_NUM_QUEUES-1:0] disp_valid;   // one-hot load
    logic [`RS_NUM_QUEUES-1:0] offer_valid;
    logic [`RS_NUM_QUEUES-1:0] grant;
    disp_pkt_t                 disp_pkt;     // shared by all queues
    issue_pkt_t                offer_pkt [`RS_NUM_QUEUES];
    wakeup_t                   wakeup;       // to queues and scoreboard

    dispatch_unit dispatch_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .queue_full (queue_full),
        .wakeup     (wakeup),
        .in_ready   (in_ready),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt)
    );

    for (genvar q = 0; q < `RS_NUM_QUEUES; q++) begin : g_queue
        issue_queue queue_i (
            .clk         (clk),
            .reset       (reset),
            .load        (disp_valid[q]),
            .entry_in    (disp_pkt),
            .wakeup      (wakeup),
            .grant       (grant[q]),
            .full        (queue_full[q]),
            .offer_valid (offer_valid[q]),
            .offer_pkt   (offer_pkt[q])
        );
    end

    issue_arbiter arbiter_i (
        .clk         (clk),
        .reset       (reset),
        .offer_valid (offer_valid),
        .offer_pkt   (offer_pkt),
        .out_ready   (out_ready),
        .grant       (grant),
        .wakeup      (wakeup),
        .out_valid   (out_valid),
        .out_pkt     (out_pkt)
    );

endmodule

`default_nettype wire

// File: tb_rs_top.sv
/* testbench for the scheduling core that checks decode, dependency order, scoreboard
   stall, back-pressure and random stress against a reference model */
`default_nettype none
`include "rs_defs.svh"

module tb_rs_top;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;
    import rs_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int N_DECODE    = 8;
    localparam int N_CHAIN     = 6;
    localparam int N_STALL     = 3;
    localparam int CAPACITY    = `RS_NUM_QUEUES * `RS_NUM_ENTRIES + 1;  // queues plus output reg
    localparam int N_BACKPR    = CAPACITY + 1;
    localparam int N_RANDOM    = 400;
    localparam int N_TOTAL     = N_DECODE + N_CHAIN + N_STALL + N_BACKPR + N_RANDOM;
    localparam int WATCHDOG_NS = (40 * N_TOTAL + 8) * CLK_PERIOD;

    // one accepted instruction in the model
    typedef struct packed {
        issue_pkt_t pkt;    // expected issue packet
        int         seq;    // acceptance order
        int         prod1;  // seq of the pending writer of src1 or -1
        int         prod2;
    } pend_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    logic       out_ready;
    logic       out_valid;
    insn_word_u in_word;
    issue_pkt_t out_pkt;

    pend_t      pending [$];
    bit         retired [int];              // seq numbers that completed the out handshake
    int         writer_of [`RS_REG_NUM];    // model busy table where -1 means ready
    int         n_accepted = 0;
    int         n_retired  = 0;
    int         n_issued   = 0;             // every out handshake, expected or not
    int         errors     = 0;
    bit         rand_ready = 1'b0;
    logic       hold_ready = 1'b0;
    logic       stalled    = 1'b0;          // output held against out_ready low last edge
    issue_pkt_t held_pkt;

    rs_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pkt   (out_pkt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // expected packet straight from the bit layout of the word
    function automatic issue_pkt_t ref_decode(input logic [31:0] w);
        issue_pkt_t p;
        p.op   = alu_op_e'(w[30:27]);
        p.dst  = w[26:22];
        p.src1 = w[21:17];
        if (w[31]) begin
            p.src2 = 5'd0;      // i-form reads r0
            p.imm  = w[16:0];
        end else begin
            p.src2 = w[16:12];
            p.imm  = 17'd0;     // no immediate in r-form
        end
        return p;
    endfunction

    function automatic logic [31:0] make_word(input logic form, input int op, input int dst,
                                              input int src1, input int src2, input int imm);
        logic [16:0] low;
        low = form ? 17'(imm) : {5'(src2), 12'($urandom)};  // random pad in r-form
        return {form, 4'(op), 5'(dst), 5'(src1), low};
    endfunction

    // starts on a falling edge and returns on the one after the transfer
    task automatic send_word(input logic [31:0] w);
        in_valid = 1'b1;
        in_word  = w;
        do @(posedge clk); while (!in_ready);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (pending.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %-12s done: accepted %0d retired %0d errors %0d",
                 name, n_accepted, n_retired, errors);
    endtask

    always @(negedge clk) begin
        if (rand_ready)
            out_ready = ($urandom_range(3) != 0);  // ready about three cycles in four
        else
            out_ready = hold_ready;
    end

    always @(posedge clk) begin : check
        pend_t      e;
        issue_pkt_t exp_pkt;
        int         idx;
        exp_pkt = ref_decode(in_word);
        if (reset) begin
            stalled = 1'b0;
        end else begin
            if (stalled)
                assert (out_valid && out_pkt == held_pkt)
                else begin
                    $display("** Error at %0t: out_pkt moved while out_ready was low", $time);
                    errors++;
                end
            // a second writer may enter only once the first sits in the output register
            if (in_valid && in_ready && exp_pkt.dst != 0)
                assert (writer_of[exp_pkt.dst] < 0 || (out_valid && out_pkt.dst == exp_pkt.dst))
                else begin
                    $display("** Error at %0t: r%0d accepted while its writer is pending",
                             $time, exp_pkt.dst);
                    errors++;
                end
            if (out_valid && out_ready) begin
                n_issued++;
                idx = -1;
                foreach (pending[i])
                    if (idx < 0 && pending[i].pkt == out_pkt)
                        idx = i;  // oldest match
                assert (idx >= 0 && !$isunknown(out_pkt))
                else begin
                    $display("** Error at %0t: unexpected issue op %0d dst r%0d src r%0d/r%0d",
                             $time, out_pkt.op, out_pkt.dst, out_pkt.src1, out_pkt.src2);
                    errors++;
                end
                if (idx >= 0) begin
                    e = pending[idx];
                    assert ((e.prod1 < 0 || retired.exists(e.prod1)) &&
                            (e.prod2 < 0 || retired.exists(e.prod2)))
                    else begin
                        $display("** Error at %0t: seq %0d issued before its producer",
                                 $time, e.seq);
                        errors++;
                    end
                    retired[e.seq] = 1'b1;
                    if (writer_of[e.pkt.dst] == e.seq)
                        writer_of[e.pkt.dst] = -1;
                    pending.delete(idx);
                    n_retired++;
                end
            end
            if (in_valid && in_ready) begin
                e.pkt   = exp_pkt;
                e.seq   = n_accepted;
                e.prod1 = (exp_pkt.src1 != 0) ? writer_of[exp_pkt.src1] : -1;
                e.prod2 = (exp_pkt.src2 != 0) ? writer_of[exp_pkt.src2] : -1;
                pending.push_back(e);
                if (exp_pkt.dst != 0)
                    writer_of[exp_pkt.dst] = e.seq;  // busy until its out handshake
                n_accepted++;
            end
            stalled  = out_valid && !out_ready;
            held_pkt = out_pkt;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns and was stopped", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] w;
        void'($urandom(32'haee6_5adf));
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_word   = '0;
        out_ready = 1'b0;
        foreach (writer_of[r])
            writer_of[r] = -1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset      = 1'b0;
        hold_ready = 1'b1;

        // independent words of both forms whose sources are never written
        for (int k = 0; k < N_DECODE; k++)
            send_word(make_word(k[0], k, k + 1, 20 + k, 28 - k, int'($urandom)));
        drain();
        report_test("decode");

        // chains with r0 mixed in as a source that never waits
        send_word(make_word(1'b1, int'(ALU_ADD), 1, 0, 0, 17'h00abc));
        send_word(make_word(1'b0, int'(ALU_XOR), 2, 1, 1, 0));
        send_word(make_word(1'b0, int'(ALU_SUB), 3, 2, 0, 0));
        send_word(make_word(1'b1, int'(ALU_SLL), 4, 3, 0, 17'h00003));
        send_word(make_word(1'b0, int'(ALU_SLT), 7, 4, 2, 0));
        send_word(make_word(1'b0, int'(ALU_AND), 0, 7, 3, 0));
        drain();
        report_test("dependency");

        // r6 writer parks in the output register and the r5 writer waits behind it
        hold_ready = 1'b0;
        @(negedge clk);
        send_word(make_word(1'b1, int'(ALU_ADD), 6, 0, 0, 17'h01234));
        send_word(make_word(1'b0, int'(ALU_OR), 5, 6, 6, 0));
        w        = make_word(1'b1, int'(ALU_SUB), 5, 0, 0, 17'h00042);
        in_valid = 1'b1;
        in_word  = w;
        repeat (8) begin
            @(posedge clk);
            assert (!in_ready)
            else begin
                $display("** Error at %0t: in_ready high while r5 has a pending writer", $time);
                errors++;
            end
        end
        @(negedge clk);
        hold_ready = 1'b1;
        send_word(w);
        drain();
        report_test("stall");

        // fill every queue entry and the output register with out_ready low
        hold_ready = 1'b0;
        @(negedge clk);
        for (int k = 0; k < CAPACITY; k++)
            send_word(make_word(1'b1, k % 8, k + 1, 0, 0, k * 3));
        w        = make_word(1'b0, int'(ALU_ADD), CAPACITY + 1, 0, 0, 0);
        in_valid = 1'b1;
        in_word  = w;
        repeat (6) begin
            @(posedge clk);
            assert (!in_ready && n_accepted - n_retired == CAPACITY)
            else begin
                $display("** Error at %0t: in_ready=%0b with %0d in flight, expected full at %0d",
                         $time, in_ready, n_accepted - n_retired, CAPACITY);
                errors++;
            end
        end
        @(negedge clk);
        hold_ready = 1'b1;
        send_word(w);
        drain();
        report_test("backpressure");

        rand_ready = 1'b1;
        for (int k = 0; k < N_RANDOM; k++)
            send_word(make_word(1'($urandom_range(1)), int'($urandom_range(7)),
                                int'($urandom_range(31)), int'($urandom_range(31)),
                                int'($urandom_range(31)), int'($urandom)));
        @(negedge clk);
        rand_ready = 1'b0;
        drain();
        assert (pending.size() == 0 && n_issued == n_accepted)
        else begin
            $display("** Error at %0t: %0d issues seen for %0d accepted instructions",
                     $time, n_issued, n_accepted);
            errors++;
        end
        report_test("random");

        $display("accepted %0d retired %0d pending %0d errors %0d",
                 n_accepted, n_retired, pending.size(), errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rs_top.f
+incdir+.
isa_pkg.sv
rs_pkg.sv
dispatch_unit.sv
issue_queue.sv
issue_arbiter.sv
rs_top.sv
tb_rs_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_rs_top
FILELIST  = rs_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST)) rs_defs.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Everything OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
